// ==== common/neo_loader_pkg.sv ====
package neo_loader_pkg;

	typedef logic [31:0] size_t;
	typedef logic [23:0] port1_addr_t;
	typedef logic [25:0] port2_addr_t;
	typedef logic [23:0] sample_addr_t;

	// Cart regions in .neo file order
	typedef enum logic [2:0] {
		REG_P  = 3'd0,
		REG_S  = 3'd1,
		REG_M  = 3'd2,
		REG_V1 = 3'd3,
		REG_V2 = 3'd4,
		REG_C  = 3'd5
	} region_e;

	typedef enum logic [1:0] {
		ST_IDLE      = 2'd0,
		ST_WAIT_ACK  = 2'd1,
		ST_CHECK_END = 2'd2
	} wr_state_e;

	localparam int IOCTL_AW  = 25;
	localparam int HDR_BITS  = 12;
	// Size fields of the .neo header
	localparam int HDR_FIRST = 4;
	localparam int HDR_LAST  = 27;
	localparam logic [7:0] IDX_CART = 8'd2;

	// Bank 3 prefixes
	localparam logic [4:0] PFX_SYSROM = 5'b1111_1;
	localparam logic [7:0] PFX_LOROM  = 8'b1101_1110;
	localparam logic [6:0] PFX_SFIX   = 7'b1110_100;
	localparam logic [5:0] PFX_SM1    = 6'b1110_11;
	localparam logic [4:0] PFX_FIX    = 5'b1110_0;
	localparam logic [4:0] PFX_MROM   = 5'b1111_0;

	// System image windows on ioctl_addr[23:17]
	localparam logic [6:0] WIN_LOROM = 7'b0000100;
	localparam logic [6:0] WIN_SFIX  = 7'b0000101;

endpackage

// ==== common/cart_layout_if.sv ====
`timescale 1ns/100ps

interface cart_layout_if import neo_loader_pkg::*; ();

	size_t p_size;
	size_t s_size;
	size_t m_size;
	size_t v1_size;
	size_t v2_size;
	size_t c_size;

	// Power of two minus one covering each ADPCM region
	size_t v1_mask;
	size_t v2_mask;

	modport parser (output p_size, s_size, m_size, v1_size, v2_size, c_size,
		v1_mask, v2_mask);

	modport user (input p_size, s_size, m_size, v1_size, v2_size, c_size,
		v1_mask, v2_mask);

endinterface

// ==== loader/neo_header_parser.sv ====
`timescale 1ns/100ps

module neo_header_parser import neo_loader_pkg::*; (
	input  logic                CLK_48M,
	input  logic                rst_n,
	input  logic                ioctl_wr,
	input  logic [IOCTL_AW-1:0] ioctl_addr,
	input  logic [7:0]          ioctl_dout,
	input  logic                cart_write,
	cart_layout_if.parser       layout
);

	logic in_header;
	logic size_byte;
	logic last_byte;

	function automatic size_t ceil_mask(input size_t value);
		int top;
		int bits;
		top = 0;
		bits = 0;
		for (int i = 0; i < 32; i++) begin
			if (value[i]) begin
				top = i;
				bits = bits + 1;
			end
		end
		// Round up when not a power of two
		if (bits > 1)
			top = top + 1;
		return (size_t'(1) << top) - size_t'(1);
	endfunction

	assign in_header = ioctl_addr[IOCTL_AW-1:HDR_BITS] == '0;
	assign size_byte = in_header && ioctl_addr >= HDR_FIRST && ioctl_addr <= HDR_LAST;
	assign last_byte = in_header && (&ioctl_addr[HDR_BITS-1:0]);

	always_ff @(posedge CLK_48M) begin
		if (!rst_n) begin
			layout.p_size <= '0;
			layout.s_size <= '0;
			layout.m_size <= '0;
			layout.v1_size <= '0;
			layout.v2_size <= '0;
			layout.c_size <= '0;
			layout.v1_mask <= '0;
			layout.v2_mask <= '0;
		end else if (cart_write) begin
			if (ioctl_wr && size_byte)
				{layout.c_size, layout.v2_size, layout.v1_size, layout.m_size,
					layout.s_size, layout.p_size} <= {ioctl_dout, layout.c_size,
					layout.v2_size, layout.v1_size, layout.m_size, layout.s_size,
					layout.p_size[31:8]};
			// V1 holds both halves of a merged ADPCM image
			if (ioctl_wr && last_byte && layout.v2_size == '0) begin
				layout.v1_size <= layout.v1_size >> 1;
				layout.v2_size <= layout.v1_size >> 1;
			end
			layout.v1_mask <= ceil_mask(layout.v1_size);
			layout.v2_mask <= ceil_mask(layout.v2_size);
		end
	end

endmodule

// ==== loader/region_sequencer.sv ====
`timescale 1ns/100ps

module region_sequencer import neo_loader_pkg::*; (
	input  logic                CLK_48M,
	input  logic                rst_n,
	input  logic                ioctl_wr,
	input  logic [IOCTL_AW-1:0] ioctl_addr,
	input  logic                cart_write,
	input  logic                system_write,
	input  logic                port1_ack,
	input  logic                port2_ack,
	cart_layout_if.user         layout,
	output logic                port1_req,
	output logic                port2_req,
	output region_e             region,
	output logic [25:0]         offset
);

	wr_state_e state;
	logic [25:0] region_size;
	logic in_header;
	logic on_port1;
	logic acked;

	always_comb begin
		case (region)
			REG_P:   region_size = layout.p_size[25:0];
			REG_S:   region_size = layout.s_size[25:0];
			REG_M:   region_size = layout.m_size[25:0];
			REG_V1:  region_size = layout.v1_size[25:0];
			REG_V2:  region_size = layout.v2_size[25:0];
			REG_C:   region_size = layout.c_size[25:0];
			default: region_size = '0;
		endcase
	end

	assign in_header = ioctl_addr[IOCTL_AW-1:HDR_BITS] == '0;
	// P, S and M live in bank 3
	assign on_port1 = region <= REG_M;
	assign acked = on_port1 ? (port1_req == port1_ack) : (port2_req == port2_ack);

	always_ff @(posedge CLK_48M) begin
		if (!rst_n) begin
			port1_req <= 1'b0;
			port2_req <= 1'b0;
			region <= REG_P;
			offset <= '0;
			state <= ST_IDLE;
		end else begin
			if (ioctl_wr && system_write) begin
				port1_req <= ~port1_req;
				state <= ST_IDLE;
			end
			if (ioctl_wr && cart_write) begin
				if (in_header) begin
					region <= REG_P;
					offset <= '0;
					if (&ioctl_addr[HDR_BITS-1:0])
						state <= ST_CHECK_END;
				end else begin
					if (on_port1)
						port1_req <= ~port1_req;
					else
						port2_req <= ~port2_req;
					state <= ST_WAIT_ACK;
				end
			end

			case (state)
				ST_WAIT_ACK: begin
					if (acked) begin
						offset <= offset + 26'd1;
						state <= ST_CHECK_END;
					end
				end
				// Stays here while empty regions are skipped
				ST_CHECK_END: begin
					if (offset == region_size) begin
						offset <= '0;
						if (region == REG_C)
							state <= ST_IDLE;
						else
							region <= region_e'(region + 3'd1);
					end else begin
						state <= ST_IDLE;
					end
				end
				default: ;
			endcase
		end
	end

endmodule

// ==== loader/loader_addr_map.sv ====
`timescale 1ns/100ps

module loader_addr_map import neo_loader_pkg::*; (
	input  logic [IOCTL_AW-1:0] ioctl_addr,
	input  logic                system_write,
	input  region_e             region,
	input  logic [25:0]         offset,
	cart_layout_if.user         layout,
	output port1_addr_t         port1_addr,
	output port2_addr_t         port2_addr
);

	port1_addr_t sys_addr;
	port1_addr_t cart_addr;
	logic [25:0] v1_base;
	logic [25:0] v2_base;

	// System image split into its four windows
	always_comb begin
		if (ioctl_addr[23:19] == '0)
			sys_addr = {PFX_SYSROM, ioctl_addr[18:0]};
		else if (ioctl_addr[23:17] == WIN_LOROM)
			sys_addr = {PFX_LOROM, ioctl_addr[15:0]};
		else if (ioctl_addr[23:17] == WIN_SFIX)
			sys_addr = {PFX_SFIX, ioctl_addr[16:5], ioctl_addr[2:0], ~ioctl_addr[4],
				ioctl_addr[3]};
		else
			sys_addr = {PFX_SM1, ioctl_addr[17:0]};
	end

	always_comb begin
		case (region)
			REG_S:   cart_addr = {PFX_FIX, offset[18:5], offset[2:0], ~offset[4], offset[3]};
			REG_M:   cart_addr = {PFX_MROM, offset[18:0]};
			default: cart_addr = offset[23:0];
		endcase
	end

	assign port1_addr = system_write ? sys_addr : cart_addr;

	// Banks 0..2 hold C, then V1, then V2
	assign v1_base = layout.c_size[25:0];
	assign v2_base = layout.c_size[25:0] + layout.v1_size[25:0];

	always_comb begin
		case (region)
			REG_V1:  port2_addr = v1_base + offset;
			REG_V2:  port2_addr = v2_base + offset;
			default: port2_addr = {offset[25:7], ioctl_addr[5:2], ~ioctl_addr[6],
				ioctl_addr[0], ioctl_addr[1]};
		endcase
	end

endmodule

// ==== design/adpcm_fetch.sv ====
`timescale 1ns/100ps

module adpcm_fetch import neo_loader_pkg::*; (
	input  logic         CLK_48M,
	input  logic         rst_n,
	input  logic         rd,
	input  sample_addr_t addr,
	input  sample_addr_t mask,
	input  logic [25:0]  base,
	input  logic         sample_ack,
	input  logic [63:0]  sample_q,
	output logic         sample_req,
	output logic [25:0]  sample_addr,
	output logic [7:0]   data,
	output logic         ready
);

	logic rd_d;
	sample_addr_t masked;
	sample_addr_t latch;

	assign masked = addr & mask;

	always_ff @(posedge CLK_48M) begin
		if (!rst_n) begin
			rd_d <= 1'b0;
			sample_req <= 1'b0;
			latch <= '0;
		end else begin
			rd_d <= rd;
			if (rd && !rd_d) begin
				// Fetch only when the 8 byte line changes
				if (masked[23:3] != latch[23:3])
					sample_req <= ~sample_req;
				latch <= masked;
			end
		end
	end

	assign sample_addr = base + {2'b00, latch};

	// Byte 0 sits in the low lane
	assign data = sample_q[{latch[2:0], 3'b000} +: 8];

	assign ready = sample_ack == sample_req;

endmodule

// ==== design/rom_loader_top.sv ====
`timescale 1ns/100ps

module rom_loader_top import neo_loader_pkg::*; (
	input  logic                CLK_48M,
	input  logic                rst_n,
	input  logic                ioctl_downl,
	input  logic [7:0]          ioctl_index,
	input  logic                ioctl_wr,
	input  logic [IOCTL_AW-1:0] ioctl_addr,
	input  logic [7:0]          ioctl_dout,
	input  logic                port1_ack,
	input  logic                port2_ack,
	input  logic [19:0]         adpcma_addr,
	input  logic [3:0]          adpcma_bank,
	input  logic                adpcma_rd,
	input  logic [23:0]         adpcmb_addr,
	input  logic                adpcmb_rd,
	input  logic                samplea_ack,
	input  logic [63:0]         samplea_q,
	input  logic                sampleb_ack,
	input  logic [63:0]         sampleb_q,
	output logic                port1_req,
	output port1_addr_t         port1_addr,
	output logic                port1_we,
	output logic [15:0]         port1_d,
	output logic                port2_req,
	output port2_addr_t         port2_addr,
	output logic                port2_we,
	output logic [15:0]         port2_d,
	output logic                samplea_req,
	output logic [25:0]         samplea_addr,
	output logic                sampleb_req,
	output logic [25:0]         sampleb_addr,
	output logic [7:0]          adpcma_data,
	output logic                adpcma_ready,
	output logic [7:0]          adpcmb_data,
	output logic                adpcmb_ready
);

	cart_layout_if layout();

	logic system_write;
	logic cart_write;
	region_e region;
	logic [25:0] offset;
	sample_addr_t bank_a_addr;
	logic [25:0] base_b;

	// Index 0 and 1 carry the system image
	assign system_write = ioctl_downl && (ioctl_index == 8'd0 || ioctl_index == 8'd1);
	assign cart_write = ioctl_downl && ioctl_index == IDX_CART;

	assign port1_we = system_write | cart_write;
	assign port2_we = cart_write;
	assign port1_d = {ioctl_dout, ioctl_dout};
	assign port2_d = {ioctl_dout, ioctl_dout};

	neo_header_parser u_parser (.CLK_48M, .rst_n, .ioctl_wr, .ioctl_addr, .ioctl_dout,
		.cart_write, .layout(layout.parser));

	region_sequencer u_sequencer (.CLK_48M, .rst_n, .ioctl_wr, .ioctl_addr, .cart_write,
		.system_write, .port1_ack, .port2_ack, .layout(layout.user), .port1_req,
		.port2_req, .region, .offset);

	loader_addr_map u_addr_map (.ioctl_addr, .system_write, .region, .offset,
		.layout(layout.user), .port1_addr, .port2_addr);

	assign bank_a_addr = {adpcma_bank, adpcma_addr};
	// V2 samples follow V1 in banks 0..2
	assign base_b = layout.c_size[25:0] + layout.v1_size[25:0];

	adpcm_fetch sample_a (.CLK_48M, .rst_n, .rd(adpcma_rd), .addr(bank_a_addr),
		.mask(layout.v1_mask[23:0]), .base(layout.c_size[25:0]), .sample_ack(samplea_ack),
		.sample_q(samplea_q), .sample_req(samplea_req), .sample_addr(samplea_addr),
		.data(adpcma_data), .ready(adpcma_ready));

	adpcm_fetch sample_b (.CLK_48M, .rst_n, .rd(adpcmb_rd), .addr(adpcmb_addr),
		.mask(layout.v2_mask[23:0]), .base(base_b), .sample_ack(sampleb_ack),
		.sample_q(sampleb_q), .sample_req(sampleb_req), .sample_addr(sampleb_addr),
		.data(adpcmb_data), .ready(adpcmb_ready));

endmodule

// ==== bench/rom_loader_tb.sv ====
`timescale 1ns/100ps

module rom_loader_tb;

	localparam int K_SYS = 0;
	localparam int K_CART = 1;
	localparam int K_SA = 2;
	localparam int K_SB = 3;
	localparam int MAX_STEPS = 256;

	logic CLK_48M = 1'b0;
	logic rst_n = 1'b0;
	logic ioctl_downl = 1'b0;
	logic [7:0] ioctl_index = '0;
	logic ioctl_wr = 1'b0;
	logic [24:0] ioctl_addr = '0;
	logic [7:0] ioctl_dout = '0;
	logic port1_ack = 1'b0;
	logic port2_ack = 1'b0;
	logic [19:0] adpcma_addr = '0;
	logic [3:0] adpcma_bank = '0;
	logic adpcma_rd = 1'b0;
	logic [23:0] adpcmb_addr = '0;
	logic adpcmb_rd = 1'b0;
	logic samplea_ack = 1'b0;
	logic [63:0] samplea_q = '0;
	logic sampleb_ack = 1'b0;
	logic [63:0] sampleb_q = '0;
	logic port1_req, port1_we, port2_req, port2_we;
	logic [23:0] port1_addr;
	logic [25:0] port2_addr;
	logic [15:0] port1_d, port2_d;
	logic samplea_req, sampleb_req, adpcma_ready, adpcmb_ready;
	logic [25:0] samplea_addr, sampleb_addr;
	logic [7:0] adpcma_data, adpcmb_data;

	// Stimulus and expected values, one row per step
	int n_steps = 0;
	int t_kind[MAX_STEPS];
	logic [7:0] t_idx[MAX_STEPS];
	logic [24:0] t_addr[MAX_STEPS];
	logic [7:0] t_data[MAX_STEPS];
	int t_port[MAX_STEPS];
	logic [25:0] t_exp_addr[MAX_STEPS];
	logic [7:0] t_exp_byte[MAX_STEPS];

	int seed = 1;
	int cycles = 0;
	int limit = 100000;
	int p1_wait = 0;
	int p2_wait = 0;
	int sa_wait = 0;
	int sb_wait = 0;
	logic [23:0] lat_a = '0;
	logic [23:0] lat_b = '0;
	logic [7:0] line_a = '0;
	logic [7:0] line_b = '0;
	// All requests start at 0 after reset
	logic exp_port1_req = 1'b0;
	logic exp_port2_req = 1'b0;
	logic exp_samplea_req = 1'b0;
	logic exp_sampleb_req = 1'b0;

	rom_loader_top uut (.*);

	always #4 CLK_48M = ~CLK_48M;

	always @(posedge CLK_48M) begin
		cycles = cycles + 1;
		if (cycles > limit) begin
			$display("Timeout after %0d cycles", cycles);
			$display("TESTBENCH FAILED");
			$fatal(1);
		end
	end

	// Memory port models answer a toggle after 1 to 6 cycles
	always @(posedge CLK_48M) begin
		if (port1_req != port1_ack) begin
			if (p1_wait == 0) begin
				p1_wait = 1 + ({$random(seed)} % 6);
			end else begin
				p1_wait = p1_wait - 1;
				if (p1_wait == 0)
					#1 port1_ack = port1_req;
			end
		end
	end

	always @(posedge CLK_48M) begin
		if (port2_req != port2_ack) begin
			if (p2_wait == 0) begin
				p2_wait = 1 + ({$random(seed)} % 6);
			end else begin
				p2_wait = p2_wait - 1;
				if (p2_wait == 0)
					#1 port2_ack = port2_req;
			end
		end
	end

	function automatic logic [63:0] line_word(input logic [25:0] a);
		logic [63:0] w;
		logic [7:0] low;
		low = {a[7:3], 3'b000};
		for (int n = 0; n < 8; n++)
			w[n*8 +: 8] = low + 8'(n);
		return w;
	endfunction

	always @(posedge CLK_48M) begin
		if (samplea_req != samplea_ack) begin
			if (sa_wait == 0) begin
				sa_wait = 1 + ({$random(seed)} % 6);
			end else begin
				sa_wait = sa_wait - 1;
				if (sa_wait == 0) begin
					#1 samplea_q = line_word(samplea_addr);
					samplea_ack = samplea_req;
				end
			end
		end
	end

	always @(posedge CLK_48M) begin
		if (sampleb_req != sampleb_ack) begin
			if (sb_wait == 0) begin
				sb_wait = 1 + ({$random(seed)} % 6);
			end else begin
				sb_wait = sb_wait - 1;
				if (sb_wait == 0) begin
					#1 sampleb_q = line_word(sampleb_addr);
					sampleb_ack = sampleb_req;
				end
			end
		end
	end

	function automatic logic [25:0] sys_map(input logic [24:0] a);
		if (a < 25'h080000)
			return {2'b00, 5'b11111, a[18:0]};
		if (a < 25'h0A0000)
			return {2'b00, 8'hDE, a[15:0]};
		if (a < 25'h0C0000)
			return {2'b00, 7'b1110100, a[16:5], a[2:0], ~a[4], a[3]};
		return {2'b00, 6'b111011, a[17:0]};
	endfunction

	function automatic logic [25:0] cart_map(input int r, input int o, input logic [24:0] a,
		input int c, input int v1);
		logic [25:0] ov;
		ov = o[25:0];
		case (r)
			0: return {2'b00, ov[23:0]};
			1: return {2'b00, 5'b11100, ov[18:5], ov[2:0], ~ov[4], ov[3]};
			2: return {2'b00, 5'b11110, ov[18:0]};
			3: return 26'(c + o);
			4: return 26'(c + v1 + o);
			default: return {ov[25:7], a[5:2], ~a[6], a[0], a[1]};
		endcase
	endfunction

	task automatic add_step(input int kind, input logic [7:0] idx, input logic [24:0] a,
		input logic [7:0] d, input int port, input logic [25:0] ea, input logic [7:0] eb);
		t_kind[n_steps] = kind;
		t_idx[n_steps] = idx;
		t_addr[n_steps] = a;
		t_data[n_steps] = d;
		t_port[n_steps] = port;
		t_exp_addr[n_steps] = ea;
		t_exp_byte[n_steps] = eb;
		n_steps = n_steps + 1;
	endtask

	task automatic add_cart(input int p, input int s, input int m, input int v1,
		input int v2, input int c);
		int sz[6];
		int pos;
		logic [7:0] b;
		sz = '{p, s, m, v1, v2, c};
		for (int i = 4; i <= 27; i++) begin
			b = 8'(sz[(i - 4) / 4] >> (8 * ((i - 4) % 4)));
			add_step(K_CART, 8'd2, 25'(i), b, 0, '0, b);
		end
		add_step(K_CART, 8'd2, 25'd4095, 8'h00, 0, '0, 8'h00);
		// Merged ADPCM image splits V1 in two
		if (sz[4] == 0) begin
			sz[3] = sz[3] / 2;
			sz[4] = sz[3];
		end
		pos = 4096;
		for (int r = 0; r < 6; r++) begin
			for (int o = 0; o < sz[r]; o++) begin
				b = 8'(pos) ^ 8'h5A;
				add_step(K_CART, 8'd2, 25'(pos), b, (r < 3) ? 1 : 2,
					cart_map(r, o, 25'(pos), sz[5], sz[3]), b);
				pos = pos + 1;
			end
		end
	endtask

	task automatic add_sample(input int kind, input logic [23:0] a, input int base,
		input int mask_v);
		logic [23:0] masked;
		logic tog;
		logic [7:0] eb;
		masked = a & mask_v[23:0];
		if (kind == K_SA) begin
			tog = masked[23:3] != lat_a[23:3];
			lat_a = masked;
			if (tog)
				line_a = 8'((base + masked) & ~7);
			eb = line_a + 8'(masked[2:0]);
		end else begin
			tog = masked[23:3] != lat_b[23:3];
			lat_b = masked;
			if (tog)
				line_b = 8'((base + masked) & ~7);
			eb = line_b + 8'(masked[2:0]);
		end
		add_step(kind, 8'd0, {1'b0, a}, 8'h00, tog ? 1 : 0, 26'(base + masked), eb);
	endtask

	task automatic check_value(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		assert (got === exp) else begin
			$display("Mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
			$display("TESTBENCH FAILED");
			$fatal(1);
		end
	endtask

	task automatic run_write(input int i);
		ioctl_downl = 1'b1;
		ioctl_index = t_idx[i];
		ioctl_addr = t_addr[i];
		ioctl_dout = t_data[i];
		ioctl_wr = 1'b1;
		@(posedge CLK_48M);
		#1;
		if (t_port[i] == 1)
			exp_port1_req = ~exp_port1_req;
		else if (t_port[i] == 2)
			exp_port2_req = ~exp_port2_req;
		check_value("port1_req", port1_req, exp_port1_req);
		check_value("port2_req", port2_req, exp_port2_req);
		if (t_port[i] == 1) begin
			check_value("port1_addr", port1_addr, t_exp_addr[i][23:0]);
			check_value("port1_we", port1_we, 1'b1);
			check_value("port1_d", port1_d, {t_exp_byte[i], t_exp_byte[i]});
		end else if (t_port[i] == 2) begin
			check_value("port2_addr", port2_addr, t_exp_addr[i]);
			check_value("port2_we", port2_we, 1'b1);
			check_value("port2_d", port2_d, {t_exp_byte[i], t_exp_byte[i]});
		end
		ioctl_wr = 1'b0;
		repeat (15) @(posedge CLK_48M);
		#1;
		assert (port1_req == port1_ack && port2_req == port2_ack) else begin
			$display("Port request still open 16 cycles after step %0d", i);
			$display("TESTBENCH FAILED");
			$fatal(1);
		end
	endtask

	task automatic run_sample(input int i);
		int n;
		logic is_a;
		is_a = t_kind[i] == K_SA;
		ioctl_downl = 1'b0;
		if (is_a) begin
			{adpcma_bank, adpcma_addr} = t_addr[i][23:0];
			adpcma_rd = 1'b1;
		end else begin
			adpcmb_addr = t_addr[i][23:0];
			adpcmb_rd = 1'b1;
		end
		@(posedge CLK_48M);
		#1;
		if (is_a) begin
			if (t_port[i] == 1) begin
				exp_samplea_req = ~exp_samplea_req;
				check_value("adpcma_ready", adpcma_ready, 1'b0);
			end
			check_value("samplea_req", samplea_req, exp_samplea_req);
			check_value("samplea_addr", samplea_addr, t_exp_addr[i]);
		end else begin
			if (t_port[i] == 1) begin
				exp_sampleb_req = ~exp_sampleb_req;
				check_value("adpcmb_ready", adpcmb_ready, 1'b0);
			end
			check_value("sampleb_req", sampleb_req, exp_sampleb_req);
			check_value("sampleb_addr", sampleb_addr, t_exp_addr[i]);
		end
		adpcma_rd = 1'b0;
		adpcmb_rd = 1'b0;
		n = 0;
		// Sampled mid-cycle, away from the model's ack
		while (!(is_a ? adpcma_ready : adpcmb_ready) && n < 12) begin
			@(negedge CLK_48M);
			n = n + 1;
		end
		assert (is_a ? adpcma_ready : adpcmb_ready) else begin
			$display("Sample fetch at step %0d never became ready", i);
			$display("TESTBENCH FAILED");
			$fatal(1);
		end
		if (is_a)
			check_value("adpcma_data", adpcma_data, t_exp_byte[i]);
		else
			check_value("adpcmb_data", adpcmb_data, t_exp_byte[i]);
		repeat (14 - n) @(posedge CLK_48M);
		#1;
	endtask

	initial begin
		add_step(K_SYS, 8'd0, 25'h012345, 8'hA1, 1, sys_map(25'h012345), 8'hA1);
		add_step(K_SYS, 8'd1, 25'h081234, 8'hB2, 1, sys_map(25'h081234), 8'hB2);
		add_step(K_SYS, 8'd0, 25'h0A0013, 8'hC3, 1, sys_map(25'h0A0013), 8'hC3);
		add_step(K_SYS, 8'd0, 25'h0C0456, 8'hD4, 1, sys_map(25'h0C0456), 8'hD4);
		add_cart(2, 18, 2, 4, 4, 4);
		// Empty P and S with merged V1
		add_cart(0, 0, 1, 64, 0, 2);
		add_sample(K_SA, 24'h500009, 2, 31);
		add_sample(K_SA, 24'h50000C, 2, 31);
		add_sample(K_SA, 24'h570013, 2, 31);
		add_sample(K_SB, 24'hABCD1A, 34, 31);
		add_sample(K_SB, 24'hFFFF1D, 34, 31);
		limit = n_steps * 20 + 200;

		repeat (8) @(posedge CLK_48M);
		#1 rst_n = 1'b1;
		@(posedge CLK_48M);
		#1;
		check_value("adpcma_ready", adpcma_ready, 1'b1);
		check_value("adpcmb_ready", adpcmb_ready, 1'b1);
		for (int i = 0; i < n_steps; i++) begin
			if (t_kind[i] == K_SYS || t_kind[i] == K_CART)
				run_write(i);
			else
				run_sample(i);
		end
		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

// ==== neo_loader.f ====
common/neo_loader_pkg.sv
common/cart_layout_if.sv
loader/neo_header_parser.sv
loader/region_sequencer.sv
loader/loader_addr_map.sv
design/adpcm_fetch.sv
design/rom_loader_top.sv
bench/rom_loader_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run with Verilator, then scan the log for a failure
verilator --binary --timing --top-module rom_loader_tb -f neo_loader.f \
	-o rom_loader_sim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/rom_loader_sim > sim.log 2>&1 || echo "simulation exited with an error" >> sim.log
cat sim.log
grep -q "TESTBENCH FAILED" sim.log && exit 1 || exit 0
